/* logic/rf_pkg.sv */
`default_nettype none

// register file sizes and word types.
package rf_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // data and pc words share one type.
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t ZERO_REG = '0; // hardwired zero register.

endpackage

`default_nettype wire

/* logic/trace_pkg.sv */
`default_nettype none

// retire trace queue types.
package trace_pkg;

    // default queue depth, must be a power of two of at least 4.
    localparam int DEFAULT_QUEUE_DEPTH = 64;

    // which lanes retire a write this cycle, encoded as {lane1, lane0}.
    typedef enum logic [1:0]
    {
        ENQ_NONE  = 2'b00,
        ENQ_LANE0 = 2'b01,
        ENQ_LANE1 = 2'b10,
        ENQ_BOTH  = 2'b11
    } enq_mode_t;

endpackage

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

// two write ports in lane order, two combinational read ports.
module regfile
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wen_a,    // older lane.
    input  rf_pkg::reg_addr_t waddr_a,
    input  rf_pkg::word_t     wdata_a,
    input  logic              wen_b,    // younger lane.
    input  rf_pkg::reg_addr_t waddr_b,
    input  rf_pkg::word_t     wdata_b,
    input  rf_pkg::reg_addr_t raddr_a,
    input  rf_pkg::reg_addr_t raddr_b,
    output rf_pkg::word_t     rdata_a,
    output rf_pkg::word_t     rdata_b
);

    import rf_pkg::*;

    word_t regs [NUM_REGS];

    logic write_a;
    logic write_b;

    // writes to the zero register are dropped.
    assign write_a = wen_a && (waddr_a != ZERO_REG);
    assign write_b = wen_b && (waddr_b != ZERO_REG);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            if (write_a)
            begin
                regs[waddr_a] <= wdata_a;
            end
            // port b comes last, so the younger lane wins a same-address pair.
            if (write_b)
            begin
                regs[waddr_b] <= wdata_b;
            end
        end
    end

    // no bypass, a same-cycle read sees the old value.
    always_comb
    begin
        if (raddr_a == ZERO_REG)
        begin
            rdata_a = '0;
        end
        else
        begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb
    begin
        if (raddr_b == ZERO_REG)
        begin
            rdata_b = '0;
        end
        else
        begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

`default_nettype wire

/* logic/rfwrite_queue.sv */
`timescale 1ns/1ps
`default_nettype none

// serializes up to two retired writes per cycle into one trace entry per cycle.
module rfwrite_queue
#(
    parameter int QUEUE_DEPTH = trace_pkg::DEFAULT_QUEUE_DEPTH
)
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             lane1_wen,
    input  rf_pkg::reg_addr_t                lane1_waddr,
    input  rf_pkg::word_t                    lane1_wdata,
    input  rf_pkg::word_t                    lane1_pc,
    input  logic                             lane0_wen,
    input  rf_pkg::reg_addr_t                lane0_waddr,
    input  rf_pkg::word_t                    lane0_wdata,
    input  rf_pkg::word_t                    lane0_pc,
    output logic                             trace_valid,
    output rf_pkg::reg_addr_t                trace_waddr,
    output rf_pkg::word_t                    trace_wdata,
    output rf_pkg::word_t                    trace_pc,
    output logic                             trace_overflow,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] trace_count
);

    import rf_pkg::*;
    import trace_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [CNT_W-1:0] DEPTH_C    = CNT_W'(QUEUE_DEPTH);
    localparam logic [CNT_W-1:0] DEPTH_M1_C = CNT_W'(QUEUE_DEPTH - 1);

    // payload storage.
    reg_addr_t waddr_q [QUEUE_DEPTH];
    word_t     wdata_q [QUEUE_DEPTH];
    word_t     pc_q    [QUEUE_DEPTH];

    logic [QUEUE_DEPTH-1:0] occ; // one occupancy bit per entry.
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [PTR_W-1:0]       tail_plus1;
    logic [PTR_W-1:0]       tail_step;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       count_next;

    enq_mode_t enq_mode;

    reg_addr_t first_waddr;
    word_t     first_wdata;
    word_t     first_pc;
    logic      first_req;
    logic      second_req;
    logic      accept_first;
    logic      accept_second;
    logic      drop;
    logic      deq;

    always_comb
    begin
        case ({lane1_wen, lane0_wen})
            2'b01:   enq_mode = ENQ_LANE0;
            2'b10:   enq_mode = ENQ_LANE1;
            2'b11:   enq_mode = ENQ_BOTH;
            default: enq_mode = ENQ_NONE;
        endcase
    end

    // lane 1 is older and goes in first; a second entry is always lane 0.
    always_comb
    begin
        first_waddr = lane1_waddr;
        first_wdata = lane1_wdata;
        first_pc    = lane1_pc;
        first_req   = 1'b0;
        second_req  = 1'b0;
        case (enq_mode)
            ENQ_LANE0:
            begin
                first_waddr = lane0_waddr;
                first_wdata = lane0_wdata;
                first_pc    = lane0_pc;
                first_req   = 1'b1;
            end
            ENQ_LANE1: first_req = 1'b1;
            ENQ_BOTH:
            begin
                first_req  = 1'b1;
                second_req = 1'b1;
            end
            default: first_req = 1'b0;
        endcase
    end

    // space is judged on the count before the edge; this edge's dequeue does not help.
    assign accept_first  = first_req && (count < DEPTH_C);
    assign accept_second = second_req && (count < DEPTH_M1_C);
    assign drop          = (first_req && !accept_first) || (second_req && !accept_second);

    assign deq        = occ[head];
    assign tail_plus1 = tail + PTR_W'(1);
    assign tail_step  = accept_second ? PTR_W'(2) : (accept_first ? PTR_W'(1) : '0);
    assign count_next = count + CNT_W'(accept_first) + CNT_W'(accept_second) - CNT_W'(deq);

    always_ff @(posedge clk)
    begin
        if (accept_first)
        begin
            waddr_q[tail] <= first_waddr;
            wdata_q[tail] <= first_wdata;
            pc_q[tail]    <= first_pc;
        end
        if (accept_second)
        begin
            waddr_q[tail_plus1] <= lane0_waddr;
            wdata_q[tail_plus1] <= lane0_wdata;
            pc_q[tail_plus1]    <= lane0_pc;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            occ            <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            trace_overflow <= 1'b0;
            trace_valid    <= 1'b0;
            trace_waddr    <= '0;
            trace_wdata    <= '0;
            trace_pc       <= '0;
        end
        else
        begin
            // tail slots are free whenever accepted, so they never alias the head.
            if (accept_first)
            begin
                occ[tail] <= 1'b1;
            end
            if (accept_second)
            begin
                occ[tail_plus1] <= 1'b1;
            end
            if (deq)
            begin
                occ[head]   <= 1'b0;
                head        <= head + PTR_W'(1);
                trace_valid <= 1'b1;
                trace_waddr <= waddr_q[head];
                trace_wdata <= wdata_q[head];
                trace_pc    <= pc_q[head];
            end
            else
            begin
                trace_valid <= 1'b0;
                trace_waddr <= '0;
                trace_wdata <= '0;
                trace_pc    <= '0;
            end
            tail  <= tail + tail_step;
            count <= count_next;
            if (drop)
            begin
                trace_overflow <= 1'b1; // sticky until reset.
            end
        end
    end

    assign trace_count = count;

endmodule

`default_nettype wire

/* logic/writeback_top.sv */
`timescale 1ns/1ps
`default_nettype none

// retire-side register write path of the dual-issue core.
module writeback_top
#(
    parameter int QUEUE_DEPTH = trace_pkg::DEFAULT_QUEUE_DEPTH
)
(
    input  logic                             clk,
    input  logic                             reset,
    // older lane.
    input  logic                             lane1_wen,
    input  rf_pkg::reg_addr_t                lane1_waddr,
    input  rf_pkg::word_t                    lane1_wdata,
    input  rf_pkg::word_t                    lane1_pc,
    // younger lane.
    input  logic                             lane0_wen,
    input  rf_pkg::reg_addr_t                lane0_waddr,
    input  rf_pkg::word_t                    lane0_wdata,
    input  rf_pkg::word_t                    lane0_pc,
    input  rf_pkg::reg_addr_t                raddr_a,
    input  rf_pkg::reg_addr_t                raddr_b,
    output rf_pkg::word_t                    rdata_a,
    output rf_pkg::word_t                    rdata_b,
    output logic                             trace_valid,
    output rf_pkg::reg_addr_t                trace_waddr,
    output rf_pkg::word_t                    trace_wdata,
    output rf_pkg::word_t                    trace_pc,
    output logic                             trace_overflow,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] trace_count
);

    // port a takes the older lane so port b's write wins.
    regfile regfile_inst
    (
        .clk     (clk),
        .reset   (reset),
        .wen_a   (lane1_wen),
        .waddr_a (lane1_waddr),
        .wdata_a (lane1_wdata),
        .wen_b   (lane0_wen),
        .waddr_b (lane0_waddr),
        .wdata_b (lane0_wdata),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    rfwrite_queue
    #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    )
    rfwrite_queue_inst
    (
        .clk            (clk),
        .reset          (reset),
        .lane1_wen      (lane1_wen),
        .lane1_waddr    (lane1_waddr),
        .lane1_wdata    (lane1_wdata),
        .lane1_pc       (lane1_pc),
        .lane0_wen      (lane0_wen),
        .lane0_waddr    (lane0_waddr),
        .lane0_wdata    (lane0_wdata),
        .lane0_pc       (lane0_pc),
        .trace_valid    (trace_valid),
        .trace_waddr    (trace_waddr),
        .trace_wdata    (trace_wdata),
        .trace_pc       (trace_pc),
        .trace_overflow (trace_overflow),
        .trace_count    (trace_count)
    );

endmodule

`default_nettype wire

/* tb/writeback_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// port-level checks on the writeback top, attached by bind.
module writeback_properties
#(
    parameter int QUEUE_DEPTH = trace_pkg::DEFAULT_QUEUE_DEPTH
)
(
    input logic                             clk,
    input logic                             reset,
    input logic                             lane1_wen,
    input logic                             lane0_wen,
    input logic                             trace_valid,
    input rf_pkg::word_t                    trace_wdata,
    input logic                             trace_overflow,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0] trace_count
);

    import trace_pkg::*;

    enq_mode_t enq_mode;

    assign enq_mode = enq_mode_t'({lane1_wen, lane0_wen});

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        32'(trace_count) <= QUEUE_DEPTH)
        else $error("trace_count above the queue depth");

    overflow_sticky: assert property (@(posedge clk) disable iff (reset)
        trace_overflow |=> trace_overflow)
        else $error("trace_overflow fell without a reset");

    idle_data_zero: assert property (@(posedge clk) disable iff (reset)
        !trace_valid |-> (trace_wdata == '0))
        else $error("trace_wdata nonzero while trace_valid is low");

    occupied_presents: assert property (@(posedge clk) disable iff (reset)
        (trace_count != '0) |=> trace_valid)
        else $error("occupied queue gave no trace entry");

    // an empty queue always has room for the first write.
    empty_accepts: assert property (@(posedge clk) disable iff (reset)
        ((trace_count == '0) && (enq_mode != ENQ_NONE)) |=> (trace_count != '0))
        else $error("write into an empty queue was not accepted");

endmodule

bind writeback_top writeback_properties #(.QUEUE_DEPTH(QUEUE_DEPTH)) writeback_properties_inst
(
    .clk            (clk),
    .reset          (reset),
    .lane1_wen      (lane1_wen),
    .lane0_wen      (lane0_wen),
    .trace_valid    (trace_valid),
    .trace_wdata    (trace_wdata),
    .trace_overflow (trace_overflow),
    .trace_count    (trace_count)
);

`default_nettype wire

/* tb/writeback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_tb;

    import rf_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int WAIT_LIMIT  = 40; // cycles before a wait gives up.

    logic      clk = 1'b0; // starts low so time zero carries no falling edge.
    logic      reset;
    logic      lane1_wen;
    reg_addr_t lane1_waddr;
    word_t     lane1_wdata;
    word_t     lane1_pc;
    logic      lane0_wen;
    reg_addr_t lane0_waddr;
    word_t     lane0_wdata;
    word_t     lane0_pc;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    logic      trace_valid;
    reg_addr_t trace_waddr;
    word_t     trace_wdata;
    word_t     trace_pc;
    logic      trace_overflow;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] trace_count;

    // reference model state.
    reg_addr_t q_waddr [$];
    word_t     q_wdata [$];
    word_t     q_pc [$];
    word_t     shadow [NUM_REGS];
    logic      exp_valid = 1'b0;
    reg_addr_t exp_waddr = '0;
    word_t     exp_wdata = '0;
    word_t     exp_pc = '0;
    logic      exp_overflow = 1'b0;
    int        drop_total = 0;

    integer seed;
    word_t  pc_next;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;

    writeback_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) writeback_top_inst
    (
        .clk            (clk),
        .reset          (reset),
        .lane1_wen      (lane1_wen),
        .lane1_waddr    (lane1_waddr),
        .lane1_wdata    (lane1_wdata),
        .lane1_pc       (lane1_pc),
        .lane0_wen      (lane0_wen),
        .lane0_waddr    (lane0_waddr),
        .lane0_wdata    (lane0_wdata),
        .lane0_pc       (lane0_pc),
        .raddr_a        (raddr_a),
        .raddr_b        (raddr_b),
        .rdata_a        (rdata_a),
        .rdata_b        (rdata_b),
        .trace_valid    (trace_valid),
        .trace_waddr    (trace_waddr),
        .trace_wdata    (trace_wdata),
        .trace_pc       (trace_pc),
        .trace_overflow (trace_overflow),
        .trace_count    (trace_count)
    );

    initial
    begin
        forever #50 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
        end
    endtask

    // space is counted from the occupancy before the edge.
    function automatic int enqueue_model(input int used, input reg_addr_t a, input word_t d,
                                         input word_t p);
        if (used < QUEUE_DEPTH)
        begin
            q_waddr.push_back(a);
            q_wdata.push_back(d);
            q_pc.push_back(p);
            return 1;
        end
        exp_overflow = 1'b1;
        drop_total++;
        return 0;
    endfunction

    always @(posedge clk)
    begin
        int used;
        if (reset)
        begin
            q_waddr.delete();
            q_wdata.delete();
            q_pc.delete();
            exp_valid    = 1'b0;
            exp_overflow = 1'b0;
            for (int i = 0; i < NUM_REGS; i++)
                shadow[i] = '0;
        end
        else
        begin
            used = q_waddr.size();
            exp_valid = (used > 0);  // the head leaves on the same edge.
            exp_waddr = exp_valid ? q_waddr.pop_front() : '0;
            exp_wdata = exp_valid ? q_wdata.pop_front() : '0;
            exp_pc    = exp_valid ? q_pc.pop_front() : '0;
            if (lane1_wen)
                used = used + enqueue_model(used, lane1_waddr, lane1_wdata, lane1_pc);
            if (lane0_wen)
                used = used + enqueue_model(used, lane0_waddr, lane0_wdata, lane0_pc);
            if (lane1_wen && lane1_waddr != '0)
                shadow[lane1_waddr] = lane1_wdata;
            if (lane0_wen && lane0_waddr != '0)
                shadow[lane0_waddr] = lane0_wdata; // younger lane lands last.
        end
    end

    always @(negedge clk)
    begin
        compare("trace_valid", 32'(trace_valid), 32'(exp_valid));
        compare("trace_waddr", 32'(trace_waddr), 32'(exp_waddr));
        compare("trace_wdata", trace_wdata, exp_wdata);
        compare("trace_pc", trace_pc, exp_pc);
        compare("trace_overflow", 32'(trace_overflow), 32'(exp_overflow));
        compare("trace_count", 32'(trace_count), 32'(q_waddr.size()));
    end

    function automatic reg_addr_t nonzero_reg();
        return reg_addr_t'(1 + ($unsigned($random(seed)) % 31));
    endfunction

    task automatic set_lanes(input logic w1, input reg_addr_t a1, input word_t d1,
                             input logic w0, input reg_addr_t a0, input word_t d0);
        lane1_wen   = w1;
        lane1_waddr = a1;
        lane1_wdata = d1;
        lane1_pc    = pc_next;
        lane0_wen   = w0;
        lane0_waddr = a0;
        lane0_wdata = d0;
        lane0_pc    = w1 ? pc_next + 32'd4 : pc_next;
        pc_next     = pc_next + ((w1 && w0) ? 32'd8 : 32'd4);
    endtask

    task automatic idle_lanes();
        lane1_wen = 1'b0;
        lane0_wen = 1'b0;
    endtask

    task automatic single_write(input logic lane, input reg_addr_t a, input word_t d);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        @(negedge clk);
        if (lane)
            set_lanes(1'b1, a, d, 1'b0, '0, '0);
        else
            set_lanes(1'b0, '0, '0, 1'b1, a, d);
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            idle_lanes();
            n++;
            seen = trace_valid;
        end
        if (!seen)
        begin
            $display("timeout: write to register %0d never reached the trace", a);
            errors++;
        end
        else
            compare("trace latency", 32'(n), 32'd2);
    endtask

    task automatic drain(output int seen);
        int n;
        bit empty;
        n = 0;
        seen = 0;
        empty = 1'b0;
        while (!empty && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            idle_lanes();
            n++;
            if (trace_valid)
                seen++;
            empty = (trace_count == '0);
        end
        if (!empty)
        begin
            $display("timeout: trace queue did not drain");
            errors++;
        end
    endtask

    task automatic read_regs(input reg_addr_t ra, input reg_addr_t rb);
        @(negedge clk);
        raddr_a = ra;
        raddr_b = rb;
        #25; // reads are combinational, sample mid phase.
        compare("rdata_a", rdata_a, shadow[ra]);
        compare("rdata_b", rdata_b, shadow[rb]);
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        $display("test %s done, %0d errors", name, errors - start);
    endtask

    task automatic reset_state_test();
        int start;
        start = errors;
        compare("trace_valid", 32'(trace_valid), 32'd0);
        compare("trace_overflow", 32'(trace_overflow), 32'd0);
        compare("trace_count", 32'(trace_count), 32'd0);
        repeat (6)
        begin
            read_regs(reg_addr_t'($random(seed)), reg_addr_t'($random(seed)));
            compare("rdata_a", rdata_a, 32'd0);
            compare("rdata_b", rdata_b, 32'd0);
        end
        report_test("reset state", start);
    endtask

    task automatic single_lane_test();
        int start;
        reg_addr_t a;
        reg_addr_t prev;
        start = errors;
        prev = '0;
        for (int i = 0; i < 6; i++)
        begin
            a = nonzero_reg();
            single_write(i[0], a, word_t'($random(seed)));
            read_regs(a, prev);
            prev = a;
        end
        report_test("single lane", start);
    endtask

    task automatic dual_retire_test();
        int start;
        int seen;
        reg_addr_t a1;
        reg_addr_t a0;
        word_t d0;
        start = errors;
        a1 = nonzero_reg();
        a0 = (a1 == 5'd31) ? 5'd1 : a1 + 5'd1;
        @(negedge clk);
        set_lanes(1'b1, a1, word_t'($random(seed)), 1'b1, a0, word_t'($random(seed)));
        drain(seen);
        compare("dual trace entries", 32'(seen), 32'd2);
        read_regs(a1, a0);
        // same register from both lanes.
        a1 = nonzero_reg();
        d0 = word_t'($random(seed));
        @(negedge clk);
        set_lanes(1'b1, a1, word_t'($random(seed)), 1'b1, a1, d0);
        drain(seen);
        compare("same-register trace entries", 32'(seen), 32'd2);
        read_regs(a1, a1);
        compare("rdata_a", rdata_a, d0);
        report_test("dual retire", start);
    endtask

    task automatic zero_reg_test();
        int start;
        int seen;
        start = errors;
        single_write(1'b0, '0, word_t'($random(seed)));
        @(negedge clk);
        set_lanes(1'b1, '0, word_t'($random(seed)), 1'b1, nonzero_reg(), word_t'($random(seed)));
        drain(seen);
        compare("zero-register trace entries", 32'(seen), 32'd2);
        read_regs('0, lane0_waddr);
        compare("rdata_a", rdata_a, 32'd0);
        report_test("register 0", start);
    endtask

    task automatic overflow_test();
        int start;
        int seen;
        int total;
        int drops_before;
        start = errors;
        total = 0;
        drops_before = drop_total;
        compare("trace_overflow", 32'(trace_overflow), 32'd0);
        repeat (10)
        begin
            @(negedge clk);
            if (trace_valid)
                total++;
            set_lanes(1'b1, nonzero_reg(), word_t'($random(seed)),
                      1'b1, nonzero_reg(), word_t'($random(seed)));
        end
        drain(seen);
        total = total + seen;
        compare("drained entries", 32'(total), 32'(20 - (drop_total - drops_before)));
        compare("trace_overflow", 32'(trace_overflow), 32'd1);
        report_test("overflow", start);
    endtask

    initial
    begin
        seed        = 94;
        pc_next     = 32'h0000_1000;
        reset       = 1'b1;
        lane1_wen   = 1'b0;
        lane1_waddr = '0;
        lane1_wdata = '0;
        lane1_pc    = '0;
        lane0_wen   = 1'b0;
        lane0_waddr = '0;
        lane0_wdata = '0;
        lane0_pc    = '0;
        raddr_a     = '0;
        raddr_b     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_state_test();
        single_lane_test();
        dual_retire_test();
        zero_reg_test();
        overflow_test();
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/rf_pkg.sv
logic/trace_pkg.sv
logic/regfile.sv
logic/rfwrite_queue.sv
logic/writeback_top.sv
tb/writeback_properties.sv
tb/writeback_tb.sv

/* run.sh */
#!/bin/sh
# compiles the writeback testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module writeback_tb -o writeback_sim &&
out=$(./obj_dir/writeback_sim) &&
echo "$out" &&
echo "$out" | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
